/* src/slc3_defines.svh */
//------------------------------------------------
// SLC-3 global parameters
// Word width, the I/O address, register count
// and the SRAM wait state count
//------------------------------------------------
`ifndef SLC3_DEFINES_SVH
`define SLC3_DEFINES_SVH

// Data and address width
`define SLC3_WORD_W 16

// Switches on read, hex display on write
`define SLC3_IO_ADDR 16'hFFFF

// General purpose registers R0..R7
`define SLC3_NUM_REGS 8

// Extra cycles an SRAM access is held
`define SLC3_MEM_WAIT 2

`endif

/* src/slc3Pkg.sv */
//------------------------------------------------
// SLC-3 shared types
// Word and index vectors, bus and ALU selects,
// opcodes and controller states
//------------------------------------------------
`include "slc3_defines.svh"

package slc3Pkg;
	typedef logic [`SLC3_WORD_W-1:0] word_t;
	typedef logic [$clog2(`SLC3_NUM_REGS)-1:0] regIdx_t;
	typedef logic [1:0] aluOp_t;
	typedef logic [1:0] busSel_t;

	// ALU functions
	localparam aluOp_t AluAdd = 2'd0;
	localparam aluOp_t AluAnd = 2'd1;
	localparam aluOp_t AluNot = 2'd2;
	localparam aluOp_t AluPassA = 2'd3;

	// Internal bus sources, one gate at a time
	localparam busSel_t BusPc = 2'd0;
	localparam busSel_t BusMdr = 2'd1;
	localparam busSel_t BusAlu = 2'd2;
	localparam busSel_t BusAddr = 2'd3;

	// LC-3 encodings of the supported subset
	typedef enum logic [3:0] {
		OpBr = 4'b0000, OpAdd = 4'b0001, OpLdr = 4'b0110, OpStr = 4'b0111,
		OpAnd = 4'b0101, OpNot = 4'b1001, OpJmp = 4'b1100, OpPause = 4'b1101
	} opcode_t;

	typedef enum logic [4:0] {
		StHalted, StFetch1, StFetch2, StFetch3, StDecode, StAdd, StAnd, StNot,
		StBr, StBrTaken, StJmp, StLdr1, StLdr2, StLdr3, StLdr4,
		StStr1, StStr2, StStr3, StStr4, StPause1, StPause2
	} ctlState_t;
endpackage

/* src/slc3Datapath.sv */
//------------------------------------------------
// SLC-3 datapath
// PC, IR, MAR, MDR and the register file around
// one internal bus, with ALU, address adder,
// condition codes and the branch-enable flag
//------------------------------------------------
`timescale 1ns/1ps
`include "slc3_defines.svh"

module slc3Datapath import slc3Pkg::*; (
	input  logic        Clk,
	input  logic        rstN,
	input  logic        ldMar,
	input  logic        ldMdr,
	input  logic        ldIr,
	input  logic        ldPc,
	input  logic        ldReg,
	input  logic        ldCc,
	input  logic        ldBen,
	input  busSel_t     busSel,
	input  logic [1:0]  pcSel,
	input  logic        addr1Sel,
	input  logic [1:0]  addr2Sel,
	input  logic        sr1Sel,
	input  logic        sr2Sel,
	input  logic        drSel,
	input  aluOp_t      aluOp,
	input  logic        mioEn,
	input  word_t       cpuRdata,
	output word_t       mar,
	output word_t       mdr,
	output opcode_t     opcode,
	output logic        ir5,
	output logic        ir11,
	output logic        ben,
	output logic [11:0] led
);
	word_t pc, ir;
	word_t regFile [`SLC3_NUM_REGS];
	regIdx_t sr1Idx, drIdx;
	word_t sr1Val, sr2Val, aluB, aluOut;
	word_t addr1, addr2, addrSum;
	word_t bus, pcNext, mdrNext;
	logic nFlag, zFlag, pFlag;

	// Status back to the controller
	assign opcode = opcode_t'(ir[15:12]);
	assign ir5 = ir[5];
	assign ir11 = ir[11];
	// LEDs track the low IR bits, PAUSE code shows here
	assign led = ir[11:0];

	//------------------------------------------------
	// Register file read and ALU
	//------------------------------------------------
	// SR1 is IR[11:9] for stores, IR[8:6] otherwise
	assign sr1Idx = sr1Sel ? ir[8:6] : ir[11:9];
	// Destination is IR[11:9] or R7
	assign drIdx = drSel ? regIdx_t'(`SLC3_NUM_REGS - 1) : ir[11:9];
	assign sr1Val = regFile[sr1Idx];
	assign sr2Val = regFile[ir[2:0]];
	// imm5, sign extended
	assign aluB = sr2Sel ? {{(`SLC3_WORD_W-5){ir[4]}}, ir[4:0]} : sr2Val;

	always_comb begin
		case (aluOp)
			AluAdd: aluOut = sr1Val + aluB;
			AluAnd: aluOut = sr1Val & aluB;
			AluNot: aluOut = ~sr1Val;
			default: aluOut = sr1Val;
		endcase
	end

	//------------------------------------------------
	// Address adder, base plus offset
	//------------------------------------------------
	assign addr1 = addr1Sel ? sr1Val : pc;

	always_comb begin
		case (addr2Sel)
			2'd1: addr2 = {{(`SLC3_WORD_W-6){ir[5]}}, ir[5:0]};
			2'd2: addr2 = {{(`SLC3_WORD_W-9){ir[8]}}, ir[8:0]};
			2'd3: addr2 = {{(`SLC3_WORD_W-11){ir[10]}}, ir[10:0]};
			default: addr2 = '0;
		endcase
	end

	assign addrSum = addr1 + addr2;

	// One source drives the bus
	always_comb begin
		case (busSel)
			BusPc: bus = pc;
			BusMdr: bus = mdr;
			BusAlu: bus = aluOut;
			default: bus = addrSum;
		endcase
	end

	// PC+1, bus or branch target
	always_comb begin
		case (pcSel)
			2'd1: pcNext = bus;
			2'd2: pcNext = addrSum;
			default: pcNext = pc + 1'b1;
		endcase
	end

	// Memory read data or bus into MDR
	assign mdrNext = mioEn ? cpuRdata : bus;

	//------------------------------------------------
	// Registers
	//------------------------------------------------
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
			nFlag <= 1'b0;
			zFlag <= 1'b0;
			pFlag <= 1'b0;
			ben <= 1'b0;
		end else begin
			if (ldPc)
				pc <= pcNext;
			if (ldIr)
				ir <= bus;
			// Codes from the value on the bus
			if (ldCc) begin
				nFlag <= bus[`SLC3_WORD_W-1];
				zFlag <= (bus == '0);
				pFlag <= !bus[`SLC3_WORD_W-1] && (bus != '0);
			end
			// Match n/z/p mask in IR[11:9]
			if (ldBen)
				ben <= (ir[11] & nFlag) | (ir[10] & zFlag) | (ir[9] & pFlag);
		end
	end

	// Payload only
	always_ff @(posedge Clk) begin
		if (ldMar)
			mar <= bus;
		if (ldMdr)
			mdr <= mdrNext;
		if (ldReg)
			regFile[drIdx] <= bus;
	end
endmodule

/* src/slc3Control.sv */
//------------------------------------------------
// SLC-3 instruction sequencer
// Multi-cycle FSM driving loads, bus gates,
// mux selects and the SRAM strobes
//------------------------------------------------
`timescale 1ns/1ps
`include "slc3_defines.svh"

module slc3Control import slc3Pkg::*; (
	input  logic       Clk,
	input  logic       rstN,
	input  logic       run,
	input  logic       resume,
	input  opcode_t    opcode,
	input  logic       ir5,
	input  logic       ir11,
	input  logic       ben,
	output logic       ldMar,
	output logic       ldMdr,
	output logic       ldIr,
	output logic       ldPc,
	output logic       ldReg,
	output logic       ldCc,
	output logic       ldBen,
	output busSel_t    busSel,
	output logic [1:0] pcSel,
	output logic       addr1Sel,
	output logic [1:0] addr2Sel,
	output logic       sr1Sel,
	output logic       sr2Sel,
	output logic       drSel,
	output aluOp_t     aluOp,
	output logic       mioEn,
	output logic       memCe,
	output logic       memOe,
	output logic       memWe,
	output logic       paused
);
	ctlState_t state, stateNext;
	logic [3:0] waitCnt;
	logic memWait, memDone;

	// Stretch states that hold the SRAM
	assign memWait = (state == StFetch2) || (state == StLdr2) || (state == StStr3);
	assign memDone = (waitCnt == 4'(`SLC3_MEM_WAIT));
	assign paused = (state == StPause1) || (state == StPause2);

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			state <= StHalted;
			waitCnt <= '0;
		end else begin
			state <= stateNext;
			waitCnt <= (memWait && !memDone) ? waitCnt + 1'b1 : '0;
		end
	end

	//------------------------------------------------
	// Next state and per-state controls
	//------------------------------------------------
	always_comb begin
		stateNext = state;
		{ldMar, ldMdr, ldIr, ldPc, ldReg, ldCc, ldBen} = '0;
		{memCe, memOe, memWe, mioEn} = '0;
		busSel = BusPc;
		pcSel = 2'd0;
		addr1Sel = 1'b0;
		addr2Sel = 2'd0;
		sr1Sel = 1'b1;
		sr2Sel = 1'b0;
		drSel = 1'b0;
		aluOp = AluPassA;
		case (state)
			StHalted: if (run) stateNext = StFetch1;
			// MAR <- PC, PC <- PC+1
			StFetch1: begin
				ldMar = 1'b1;
				ldPc = 1'b1;
				stateNext = StFetch2;
			end
			// Read held for the wait count, then captured
			StFetch2: begin
				{memCe, memOe} = 2'b11;
				if (memDone) begin
					ldMdr = 1'b1;
					mioEn = 1'b1;
					stateNext = StFetch3;
				end
			end
			StFetch3: begin
				busSel = BusMdr;
				ldIr = 1'b1;
				stateNext = StDecode;
			end
			StDecode: begin
				ldBen = 1'b1;
				case (opcode)
					OpAdd: stateNext = StAdd;
					OpAnd: stateNext = StAnd;
					OpNot: stateNext = StNot;
					OpBr: stateNext = StBr;
					// Reserved bit set, treat as no-op
					OpJmp: stateNext = ir11 ? StFetch1 : StJmp;
					OpLdr: stateNext = StLdr1;
					OpStr: stateNext = StStr1;
					OpPause: stateNext = StPause1;
					default: stateNext = StFetch1;
				endcase
			end
			// DR <- SR1 op (SR2 or imm5), codes follow
			StAdd, StAnd, StNot: begin
				busSel = BusAlu;
				sr2Sel = ir5;
				aluOp = (state == StAdd) ? AluAdd : (state == StAnd) ? AluAnd : AluNot;
				ldReg = 1'b1;
				ldCc = 1'b1;
				stateNext = StFetch1;
			end
			StBr: stateNext = ben ? StBrTaken : StFetch1;
			// PC <- PC + off9
			StBrTaken: begin
				pcSel = 2'd2;
				addr2Sel = 2'd2;
				ldPc = 1'b1;
				stateNext = StFetch1;
			end
			// PC <- BaseR through the ALU
			StJmp: begin
				busSel = BusAlu;
				pcSel = 2'd1;
				ldPc = 1'b1;
				stateNext = StFetch1;
			end
			// MAR <- BaseR + off6, shared by LDR and STR
			StLdr1, StStr1: begin
				busSel = BusAddr;
				addr1Sel = 1'b1;
				addr2Sel = 2'd1;
				ldMar = 1'b1;
				stateNext = (state == StLdr1) ? StLdr2 : StStr2;
			end
			StLdr2: begin
				{memCe, memOe} = 2'b11;
				if (memDone)
					stateNext = StLdr3;
			end
			StLdr3: begin
				{memCe, memOe} = 2'b11;
				ldMdr = 1'b1;
				mioEn = 1'b1;
				stateNext = StLdr4;
			end
			StLdr4: begin
				busSel = BusMdr;
				ldReg = 1'b1;
				ldCc = 1'b1;
				stateNext = StFetch1;
			end
			// MDR <- SR from IR[11:9]
			StStr2: begin
				busSel = BusAlu;
				sr1Sel = 1'b0;
				ldMdr = 1'b1;
				stateNext = StStr3;
			end
			StStr3: begin
				{memCe, memWe} = 2'b11;
				if (memDone)
					stateNext = StStr4;
			end
			// Write recovery, strobes released
			StStr4: stateNext = StFetch1;
			// Wait for press, then release
			StPause1: if (resume) stateNext = StPause2;
			StPause2: if (!resume) stateNext = StFetch1;
			default: stateNext = StHalted;
		endcase
	end
endmodule

/* src/slc3MemIo.sv */
//------------------------------------------------
// SLC-3 memory-mapped I/O
// Switches and hex display at the I/O address,
// SRAM strobes masked there
//------------------------------------------------
`timescale 1ns/1ps
`include "slc3_defines.svh"

module slc3MemIo import slc3Pkg::*; (
	input  logic  Clk,
	input  logic  rstN,
	input  word_t mar,
	input  word_t mdr,
	input  logic  memCe,
	input  logic  memOe,
	input  logic  memWe,
	input  word_t switches,
	input  word_t sramRdata,
	output logic  sramCe,
	output logic  sramOe,
	output logic  sramWe,
	output word_t sramAddr,
	output word_t sramWdata,
	output word_t cpuRdata,
	output word_t hexValue
);
	logic isIo;

	assign isIo = (mar == `SLC3_IO_ADDR);

	// SRAM stays idle during I/O cycles
	assign sramCe = memCe && !isIo;
	assign sramOe = memOe && !isIo;
	assign sramWe = memWe && !isIo;
	assign sramAddr = mar;
	assign sramWdata = mdr;

	// Read steering
	assign cpuRdata = (isIo && memOe) ? switches : sramRdata;

	// Display register, written by STR to the I/O address
	always_ff @(posedge Clk) begin
		if (!rstN)
			hexValue <= '0;
		else if (memCe && memWe && isIo)
			hexValue <= mdr;
	end
endmodule

/* src/slc3Top.sv */
//------------------------------------------------
// SLC-3 top level
// Controller, datapath and memory I/O block
// in front of an external asynchronous SRAM
//------------------------------------------------
`timescale 1ns/1ps

module slc3Top import slc3Pkg::*; (
	input  logic        Clk,
	input  logic        rstN,
	input  logic        run,
	input  logic        resume,
	input  word_t       switches,
	input  word_t       sramRdata,
	output logic        sramCe,
	output logic        sramOe,
	output logic        sramWe,
	output word_t       sramAddr,
	output word_t       sramWdata,
	output word_t       hexValue,
	output logic [11:0] led,
	output logic        paused
);
	// Controller to datapath
	logic ldMar, ldMdr, ldIr, ldPc, ldReg, ldCc, ldBen;
	busSel_t busSel;
	logic [1:0] pcSel, addr2Sel;
	logic addr1Sel, sr1Sel, sr2Sel, drSel;
	aluOp_t aluOp;
	logic mioEn, memCe, memOe, memWe;
	// Datapath status and memory side
	opcode_t opcode;
	logic ir5, ir11, ben;
	word_t mar, mdr, cpuRdata;

	slc3Control ctl0 (
		.Clk(Clk), .rstN(rstN), .run(run), .resume(resume),
		.opcode(opcode), .ir5(ir5), .ir11(ir11), .ben(ben),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldPc(ldPc),
		.ldReg(ldReg), .ldCc(ldCc), .ldBen(ldBen), .busSel(busSel),
		.pcSel(pcSel), .addr1Sel(addr1Sel), .addr2Sel(addr2Sel), .sr1Sel(sr1Sel),
		.sr2Sel(sr2Sel), .drSel(drSel), .aluOp(aluOp), .mioEn(mioEn),
		.memCe(memCe), .memOe(memOe), .memWe(memWe), .paused(paused)
	);

	slc3Datapath dp0 (
		.Clk(Clk), .rstN(rstN),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldPc(ldPc),
		.ldReg(ldReg), .ldCc(ldCc), .ldBen(ldBen), .busSel(busSel),
		.pcSel(pcSel), .addr1Sel(addr1Sel), .addr2Sel(addr2Sel), .sr1Sel(sr1Sel),
		.sr2Sel(sr2Sel), .drSel(drSel), .aluOp(aluOp), .mioEn(mioEn),
		.cpuRdata(cpuRdata), .mar(mar), .mdr(mdr), .opcode(opcode),
		.ir5(ir5), .ir11(ir11), .ben(ben), .led(led)
	);

	slc3MemIo mio0 (
		.Clk(Clk), .rstN(rstN), .mar(mar), .mdr(mdr),
		.memCe(memCe), .memOe(memOe), .memWe(memWe),
		.switches(switches), .sramRdata(sramRdata),
		.sramCe(sramCe), .sramOe(sramOe), .sramWe(sramWe),
		.sramAddr(sramAddr), .sramWdata(sramWdata),
		.cpuRdata(cpuRdata), .hexValue(hexValue)
	);
endmodule

/* testbench/slc3Tb.sv */
//------------------------------------------------
// SLC-3 testbench
// SRAM model, program table with switch stimulus
// from an LFSR, run to PAUSE and check display,
// LEDs and recorded SRAM writes
//------------------------------------------------
`timescale 1ns/1ps
`include "slc3_defines.svh"

module slc3Tb import slc3Pkg::*; ();
	localparam int NumTests = 7;
	localparam int MaxWords = 16;
	localparam int TimeoutCycles = 2000;
	localparam word_t RamAddr = 16'h0040;

	logic Clk, rstN, run, resume;
	word_t switches, sramRdata, sramAddr, sramWdata, hexValue;
	logic sramCe, sramOe, sramWe, paused;
	logic [11:0] led;

	// SRAM contents and what the monitors saw
	word_t sramMem [0:(1 << `SLC3_WORD_W) - 1];
	word_t writeLog [$];
	word_t hexLog [$];
	word_t lastHex;
	logic ioStrobeSeen;

	// Test table, one row per PAUSE reached
	string tName [NumTests];
	word_t tProg [NumTests][MaxWords];
	int tLen [NumTests];
	logic tNew [NumTests];
	word_t tSw [NumTests];
	word_t tHex [NumTests];
	logic [11:0] tLed [NumTests];
	int tHexChanges [NumTests];
	logic tRamChk [NumTests];
	word_t tRamAddr [NumTests];
	word_t tRamVal [NumTests];

	logic [31:0] lfsr;
	string curName;
	int curRow;

	slc3Top dut0 (
		.Clk(Clk), .rstN(rstN), .run(run), .resume(resume),
		.switches(switches), .sramRdata(sramRdata),
		.sramCe(sramCe), .sramOe(sramOe), .sramWe(sramWe),
		.sramAddr(sramAddr), .sramWdata(sramWdata),
		.hexValue(hexValue), .led(led), .paused(paused)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	//------------------------------------------------
	// SRAM model and monitors
	//------------------------------------------------
	// Asynchronous read
	assign sramRdata = sramMem[sramAddr];

	always @(posedge Clk) begin
		if (sramCe && sramWe) begin
			sramMem[sramAddr] <= sramWdata;
			writeLog.push_back(sramAddr);
		end
		// SRAM must stay idle at the I/O address
		if (rstN && (sramCe || sramOe || sramWe) && sramAddr == `SLC3_IO_ADDR)
			ioStrobeSeen <= 1'b1;
	end

	// Every new display value
	always @(negedge Clk) begin
		if (rstN && hexValue !== lastHex)
			hexLog.push_back(hexValue);
		lastHex = hexValue;
	end

	//------------------------------------------------
	// Stimulus helpers
	//------------------------------------------------
	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t randWord();
		word_t v;
		v = '0;
		for (int i = 0; i < `SLC3_WORD_W; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[`SLC3_WORD_W-2:0], lfsr[0]};
		end
		return v;
	endfunction

	// LC-3 instruction encodings
	function automatic word_t encAlu(input opcode_t op, input regIdx_t dr, input regIdx_t sr1,
		input logic imm, input logic [4:0] v);
		return {op, dr, sr1, imm, v};
	endfunction

	function automatic word_t encNot(input regIdx_t dr, input regIdx_t sr);
		return {OpNot, dr, sr, 6'b111111};
	endfunction

	function automatic word_t encBr(input logic n, input logic z, input logic p,
		input logic [8:0] off);
		return {OpBr, n, z, p, off};
	endfunction

	function automatic word_t encJmp(input regIdx_t base);
		return {OpJmp, 3'b000, base, 6'b000000};
	endfunction

	function automatic word_t encMem(input opcode_t op, input regIdx_t r, input regIdx_t base,
		input logic [5:0] off);
		return {op, r, base, off};
	endfunction

	function automatic word_t encPause(input logic [11:0] code);
		return {OpPause, code};
	endfunction

	task automatic newRow(input string name, input logic isNew, input word_t sw);
		curRow++;
		tName[curRow] = name;
		tNew[curRow] = isNew;
		tSw[curRow] = sw;
		tLen[curRow] = 0;
		tHexChanges[curRow] = 1;
		tRamChk[curRow] = 1'b0;
		tRamAddr[curRow] = '0;
		tRamVal[curRow] = '0;
	endtask

	task automatic addWord(input word_t w);
		tProg[curRow][tLen[curRow]] = w;
		tLen[curRow]++;
	endtask

	// R1 <- 16'hFFFF, base for I/O accesses
	task automatic addIoPointer();
		addWord(encAlu(OpAnd, 3'd1, 3'd1, 1'b1, 5'd0));
		addWord(encAlu(OpAdd, 3'd1, 3'd1, 1'b1, 5'h1F));
	endtask

	//------------------------------------------------
	// Program table and expected results
	//------------------------------------------------
	task automatic buildTable();
		word_t sw;
		word_t sum;
		curRow = -1;
		// LDR, ADD imm, AND reg, NOT, STR
		sw = randWord();
		newRow("alu", 1'b1, sw);
		addIoPointer();
		addWord(encMem(OpLdr, 3'd2, 3'd1, 6'd0));
		addWord(encAlu(OpAdd, 3'd3, 3'd2, 1'b1, 5'd7));
		addWord(encAlu(OpAnd, 3'd4, 3'd3, 1'b0, 5'd2));
		addWord(encNot(3'd5, 3'd4));
		addWord(encMem(OpStr, 3'd5, 3'd1, 6'd0));
		addWord(encPause(12'hA11));
		sum = sw + 16'd7;
		tHex[curRow] = ~(sum & sw);
		tLed[curRow] = 12'hA11;
		// Count down low nibble, at least one pass
		sw = randWord();
		if (sw[3:0] == 4'd0)
			sw[0] = 1'b1;
		newRow("brLoop", 1'b1, sw);
		addIoPointer();
		addWord(encMem(OpLdr, 3'd2, 3'd1, 6'd0));
		addWord(encAlu(OpAnd, 3'd2, 3'd2, 1'b1, 5'd15));
		addWord(encAlu(OpAnd, 3'd3, 3'd3, 1'b1, 5'd0));
		addWord(encAlu(OpAdd, 3'd3, 3'd3, 1'b1, 5'd1));
		addWord(encAlu(OpAdd, 3'd2, 3'd2, 1'b1, 5'h1F));
		// Back to word 5
		addWord(encBr(1'b0, 1'b0, 1'b1, 9'h1FD));
		addWord(encMem(OpStr, 3'd3, 3'd1, 6'd0));
		addWord(encPause(12'hB21));
		tHex[curRow] = {12'd0, sw[3:0]};
		tLed[curRow] = 12'hB21;
		// BRz with positive codes falls through, 5 + 3
		sw = randWord();
		newRow("brSkip", 1'b1, sw);
		addIoPointer();
		addWord(encAlu(OpAnd, 3'd2, 3'd2, 1'b1, 5'd0));
		addWord(encAlu(OpAdd, 3'd2, 3'd2, 1'b1, 5'd5));
		addWord(encBr(1'b0, 1'b1, 1'b0, 9'd1));
		addWord(encAlu(OpAdd, 3'd2, 3'd2, 1'b1, 5'd3));
		addWord(encMem(OpStr, 3'd2, 3'd1, 6'd0));
		addWord(encPause(12'hC31));
		tHex[curRow] = 16'd8;
		tLed[curRow] = 12'hC31;
		// JMP R2 to word 8 over a store of FFFE
		sw = randWord();
		if (sw == '0 || sw == 16'hFFFE)
			sw = 16'h1234;
		newRow("jmp", 1'b1, sw);
		addIoPointer();
		addWord(encAlu(OpAnd, 3'd2, 3'd2, 1'b1, 5'd0));
		addWord(encAlu(OpAdd, 3'd2, 3'd2, 1'b1, 5'd8));
		addWord(encAlu(OpAnd, 3'd3, 3'd3, 1'b1, 5'd0));
		addWord(encAlu(OpAdd, 3'd3, 3'd3, 1'b1, 5'h1E));
		addWord(encJmp(3'd2));
		addWord(encMem(OpStr, 3'd3, 3'd1, 6'd0));
		addWord(encMem(OpLdr, 3'd4, 3'd1, 6'd0));
		addWord(encMem(OpStr, 3'd4, 3'd1, 6'd0));
		addWord(encPause(12'hD41));
		tHex[curRow] = sw;
		tLed[curRow] = 12'hD41;
		// R3 = 60, offset 4 reaches 16'h0040
		sw = randWord();
		if (sw == 16'hFFFF)
			sw = 16'h00FF;
		newRow("ram", 1'b1, sw);
		addIoPointer();
		addWord(encMem(OpLdr, 3'd2, 3'd1, 6'd0));
		addWord(encAlu(OpAnd, 3'd3, 3'd3, 1'b1, 5'd0));
		repeat (4)
			addWord(encAlu(OpAdd, 3'd3, 3'd3, 1'b1, 5'd15));
		addWord(encMem(OpStr, 3'd2, 3'd3, 6'd4));
		addWord(encMem(OpLdr, 3'd4, 3'd3, 6'd4));
		addWord(encAlu(OpAdd, 3'd4, 3'd4, 1'b1, 5'd1));
		addWord(encMem(OpStr, 3'd4, 3'd1, 6'd0));
		addWord(encPause(12'hE51));
		tHex[curRow] = sw + 16'd1;
		tLed[curRow] = 12'hE51;
		tRamChk[curRow] = 1'b1;
		tRamAddr[curRow] = RamAddr;
		tRamVal[curRow] = sw;
		// PAUSE first, display write only after resume
		sw = randWord();
		if (sw == '0)
			sw = 16'h0001;
		newRow("pause1", 1'b1, sw);
		addWord(encPause(12'h1F0));
		addIoPointer();
		addWord(encMem(OpLdr, 3'd2, 3'd1, 6'd0));
		addWord(encMem(OpStr, 3'd2, 3'd1, 6'd0));
		addWord(encPause(12'h2E0));
		tHex[curRow] = '0;
		tLed[curRow] = 12'h1F0;
		tHexChanges[curRow] = 0;
		newRow("pause2", 1'b0, sw);
		tHex[curRow] = sw;
		tLed[curRow] = 12'h2E0;
	endtask

	//------------------------------------------------
	// Checks
	//------------------------------------------------
	task automatic abortRun();
		$display("TEST FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkWord(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %h, actual %h", curName, what, exp, act);
			abortRun();
		end
	endtask

	task automatic checkLed(input string what, input logic [11:0] exp, input logic [11:0] act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %h, actual %h", curName, what, exp, act);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %b, actual %b", curName, what, exp, act);
			abortRun();
		end
	endtask

	task automatic waitPaused(input logic level, input string what);
		int cnt;
		cnt = 0;
		while (paused !== level && cnt < TimeoutCycles) begin
			@(negedge Clk);
			cnt++;
		end
		if (paused !== level) begin
			$display("Timeout waiting for %s in test %s", what, curName);
			abortRun();
		end
	endtask

	//------------------------------------------------
	// Sequencing
	//------------------------------------------------
	task automatic fillMemory();
		for (int a = 0; a < (1 << `SLC3_WORD_W); a++)
			sramMem[a] = word_t'(a) ^ 16'h5AA5;
	endtask

	task automatic loadProgram(input int i);
		fillMemory();
		for (int k = 0; k < tLen[i]; k++)
			sramMem[k] = tProg[i][k];
	endtask

	// Logs cleared while reset is held
	task automatic applyReset();
		@(negedge Clk);
		rstN = 1'b0;
		repeat (5) @(negedge Clk);
		writeLog.delete();
		hexLog.delete();
		ioStrobeSeen = 1'b0;
		rstN = 1'b1;
	endtask

	// Halted with run low, nothing moves
	task automatic checkIdle();
		repeat (20) begin
			@(negedge Clk);
			checkFlag("sramCe", 1'b0, sramCe);
			checkFlag("sramOe", 1'b0, sramOe);
			checkFlag("sramWe", 1'b0, sramWe);
			checkWord("hexValue", '0, hexValue);
		end
		checkWord("sram writes", '0, word_t'(writeLog.size()));
	endtask

	// Press, hold, release
	task automatic pressResume(input word_t heldHex);
		resume = 1'b1;
		repeat (3) begin
			@(negedge Clk);
			checkFlag("paused while held", 1'b1, paused);
			checkWord("hexValue while held", heldHex, hexValue);
		end
		resume = 1'b0;
		waitPaused(1'b0, "resume release");
	endtask

	task automatic checkRow(input int i);
		checkWord("hexValue", tHex[i], hexValue);
		checkLed("led", tLed[i], led);
		checkWord("display changes", word_t'(tHexChanges[i]), word_t'(hexLog.size()));
		checkFlag("sram strobe at io address", 1'b0, ioStrobeSeen);
		if (tRamChk[i]) begin
			checkFlag("sram write seen", 1'b1, writeLog.size() > 0);
			foreach (writeLog[k])
				checkWord("sram write address", tRamAddr[i], writeLog[k]);
			checkWord("sram word", tRamVal[i], sramMem[tRamAddr[i]]);
		end else begin
			checkWord("sram writes", '0, word_t'(writeLog.size()));
		end
	endtask

	task automatic runRow(input int i);
		curName = tName[i];
		@(negedge Clk);
		switches = tSw[i];
		if (tNew[i]) begin
			loadProgram(i);
			applyReset();
			run = 1'b1;
			@(negedge Clk);
			run = 1'b0;
		end else begin
			pressResume(tHex[i-1]);
		end
		waitPaused(1'b1, "pause");
		checkRow(i);
	endtask

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		resume = 1'b0;
		switches = '0;
		ioStrobeSeen = 1'b0;
		lastHex = '0;
		lfsr = 32'hf9f5_e11f;
		curName = "reset";
		fillMemory();
		buildTable();
		applyReset();
		checkIdle();
		for (int i = 0; i < NumTests; i++)
			runRow(i);
		$display("TEST PASS");
		$finish;
	end
endmodule

/* src.f */
+incdir+src
src/slc3Pkg.sv
src/slc3Datapath.sv
src/slc3Control.sv
src/slc3MemIo.sv
src/slc3Top.sv
testbench/slc3Tb.sv

/* Bender.yml */
package:
  name: slc3

sources:
  - include_dirs:
      - src
    files:
      - src/slc3Pkg.sv
      - src/slc3Datapath.sv
      - src/slc3Control.sv
      - src/slc3MemIo.sv
      - src/slc3Top.sv
      - target: test
        files:
          - testbench/slc3Tb.sv
